//--- Bender.yml
package:
  name: mac_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/macPkg.sv
      - design/wishboneLink.sv
      - design/partialProductGen.sv
      - design/productQueue.sv
      - design/accumulateCombiner.sv
      - design/macUnit.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/macUnitTb.sv

//--- design/accumulateCombiner.sv
// Column-sum and accumulate stage
// Reads partial-product payloads from the queue, adds them by column
// into the 64-bit product, then applies the operation to the accumulator
// and holds the result until it is taken

`default_nettype none

`include "mac_config.svh"

module accumulateCombiner import macPkg::*; (
    input  wire                 Clock,
    input  wire                 nReset,
    wishboneLink.master         pop,
    input  wire                 resultReady,
    output logic                resultValid,
    output logic [AccWidth-1:0] result
);

    localparam int DigitWidth = `MAC_DIGIT_WIDTH;
    localparam int Digits     = `MAC_DIGITS;

    logic [AccWidth-1:0]   productSum;
    logic                  readDone;

    logic                  s1Valid;
    macOp_t                s1Op;
    logic [AccWidth-1:0]   s1Product;
    logic [CountWidth-1:0] s1Count;
    logic                  s1Advance;

    logic [AccWidth-1:0]   accumulator;
    logic [AccWidth-1:0]   accSum;

    //----------------------------------------------------------------------
    // Read side
    //----------------------------------------------------------------------
    // Request only while stage one is empty, so stb holds until ack
    assign pop.cyc  = !s1Valid;
    assign pop.stb  = !s1Valid;
    assign pop.we   = 1'b0;
    assign pop.datW = '0;

    assign readDone = pop.stb && pop.ack;

    // Column i+j sits at a shift of DigitWidth*(i+j), 0 up to 48
    always_comb begin
        productSum = '0;
        for (int i = 0; i < Digits; i++) begin
            for (int j = 0; j < Digits; j++) begin
                productSum = productSum +
                    (AccWidth'(pop.datR.partials[i*Digits + j]) << (DigitWidth * (i + j)));
            end
        end
    end

    //----------------------------------------------------------------------
    // Stage one
    //----------------------------------------------------------------------
    assign s1Advance = s1Valid && (!resultValid || resultReady);

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset)
            s1Valid <= 1'b0;
        else if (readDone)
            s1Valid <= 1'b1;
        else if (s1Advance)
            s1Valid <= 1'b0;
    end

    always_ff @(posedge Clock) begin
        if (readDone) begin
            s1Op      <= pop.datR.op;
            s1Product <= productSum;
            s1Count   <= pop.datR.count;
        end
    end

    //----------------------------------------------------------------------
    // Stage two
    //----------------------------------------------------------------------
    // Wraps modulo 2^64
    assign accSum = accumulator + s1Product;

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            resultValid <= 1'b0;
            accumulator <= '0;
        end else if (s1Advance) begin
            resultValid <= 1'b1;
            case (s1Op)
                MultU:   accumulator <= s1Product;
                MAddU:   accumulator <= accSum;
                default: accumulator <= accumulator;
            endcase
        end else if (resultReady) begin
            resultValid <= 1'b0;
        end
    end

    always_ff @(posedge Clock) begin
        if (s1Advance) begin
            case (s1Op)
                MultU:   result <= s1Product;
                MAddU:   result <= accSum;
                default: result <= AccWidth'(s1Count);
            endcase
        end
    end

    // Stalled result keeps its value
    assert property (@(posedge Clock) disable iff (!nReset)
        resultValid && !resultReady |=> resultValid && $stable(result));

endmodule

`default_nettype wire

//--- design/macPkg.sv
// Multiply-accumulate package
// Operation codes and the partial-product payload that travels from the
// partial-product generator through the queue to the accumulate stage

`default_nettype none

`include "mac_config.svh"

package macPkg;

    // Width of one digit-by-digit product
    localparam int ProductWidth = 2 * `MAC_DIGIT_WIDTH;

    // One product per digit pair
    localparam int PairCount = `MAC_DIGITS * `MAC_DIGITS;

    // Leading counts run 0 to MAC_DATA_WIDTH inclusive
    localparam int CountWidth = $clog2(`MAC_DATA_WIDTH + 1);

    // Full product and accumulator
    localparam int AccWidth = 2 * `MAC_DATA_WIDTH;

    //----------------------------------------------------------------------
    // Operations
    //----------------------------------------------------------------------
    typedef enum logic [1:0] {
        MultU      = 2'd0,
        MAddU      = 2'd1,
        CountZeros = 2'd2,
        CountOnes  = 2'd3
    } macOp_t;

    //----------------------------------------------------------------------
    // Payload between producer and consumer
    //----------------------------------------------------------------------
    // partials[i*MAC_DIGITS + j] holds digit i of A times digit j of B
    typedef struct packed {
        macOp_t                                   op;
        logic [PairCount-1:0][ProductWidth-1:0]   partials;
        logic [CountWidth-1:0]                    count;
    } partialSet_t;

endpackage

`default_nettype wire

//--- design/macUnit.sv
// Multiply-accumulate unit, top level
// Unsigned 32x32 multiply, multiply-accumulate into a 64-bit register and
// leading zero/one count. Operations enter and results leave on plain
// valid/ready pairs, in acceptance order

`default_nettype none

`include "mac_config.svh"

module macUnit import macPkg::*; (
    input  wire                        Clock,
    input  wire                        nReset,
    input  wire                        opValid,
    input  wire macOp_t                opCode,
    input  wire [`MAC_DATA_WIDTH-1:0]  operandA,
    input  wire [`MAC_DATA_WIDTH-1:0]  operandB,
    input  wire                        resultReady,
    output logic                       opReady,
    output logic                       resultValid,
    output logic [AccWidth-1:0]        result
);

    // Generator to queue, and queue to accumulate stage
    wishboneLink pushLink ();
    wishboneLink popLink ();

    partialProductGen producer (
        .Clock    (Clock),
        .nReset   (nReset),
        .opValid  (opValid),
        .opCode   (opCode),
        .operandA (operandA),
        .operandB (operandB),
        .opReady  (opReady),
        .push     (pushLink.master)
    );

    productQueue queue (
        .Clock  (Clock),
        .nReset (nReset),
        .push   (pushLink.slave),
        .pop    (popLink.slave)
    );

    accumulateCombiner consumer (
        .Clock       (Clock),
        .nReset      (nReset),
        .pop         (popLink.master),
        .resultReady (resultReady),
        .resultValid (resultValid),
        .result      (result)
    );

endmodule

`default_nettype wire

//--- design/partialProductGen.sv
// Partial-product generator
// Accepts an operation and its operands, forms all sixteen 8x8 digit
// products and the leading count of operand A, and writes the result
// as one payload on a Wishbone classic link

`default_nettype none

`include "mac_config.svh"

module partialProductGen import macPkg::*; (
    input  wire                        Clock,
    input  wire                        nReset,
    input  wire                        opValid,
    input  wire macOp_t                opCode,
    input  wire [`MAC_DATA_WIDTH-1:0]  operandA,
    input  wire [`MAC_DATA_WIDTH-1:0]  operandB,
    output logic                       opReady,
    wishboneLink.master                push
);

    localparam int DigitWidth = `MAC_DIGIT_WIDTH;
    localparam int Digits     = `MAC_DIGITS;

    partialSet_t nextSet;
    partialSet_t heldSet;
    logic        holdValid;
    logic        pushDone;

    // Number of leading bits equal to target, scanning from the MSB
    function automatic logic [CountWidth-1:0] leadingCount(
        input logic [`MAC_DATA_WIDTH-1:0] value,
        input logic                       target
    );
        logic [CountWidth-1:0] total;
        logic                  running;
        total   = '0;
        running = 1'b1;
        for (int k = `MAC_DATA_WIDTH - 1; k >= 0; k--) begin
            if (running && (value[k] == target))
                total = total + 1'b1;
            else
                running = 1'b0;
        end
        return total;
    endfunction

    //----------------------------------------------------------------------
    // Digit products and leading count
    //----------------------------------------------------------------------
    always_comb begin
        nextSet.op = opCode;
        for (int i = 0; i < Digits; i++) begin
            for (int j = 0; j < Digits; j++) begin
                nextSet.partials[i*Digits + j] =
                    ProductWidth'(operandA[i*DigitWidth +: DigitWidth]) *
                    ProductWidth'(operandB[j*DigitWidth +: DigitWidth]);
            end
        end
        // Ones are counted for CountOnes only
        nextSet.count = leadingCount(operandA, opCode == CountOnes);
    end

    assign pushDone = push.stb && push.ack;
    assign opReady  = !holdValid || pushDone;

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset)
            holdValid <= 1'b0;
        else if (opValid && opReady)
            holdValid <= 1'b1;
        else if (pushDone)
            holdValid <= 1'b0;
    end

    // Payload register
    always_ff @(posedge Clock) begin
        if (opValid && opReady)
            heldSet <= nextSet;
    end

    assign push.cyc  = holdValid;
    assign push.stb  = holdValid;
    assign push.we   = 1'b1;
    assign push.datW = heldSet;

    // Held write stays put until the queue takes it
    assert property (@(posedge Clock) disable iff (!nReset)
        push.stb && !push.ack |=> push.stb && $stable(push.datW));

endmodule

`default_nettype wire

//--- design/productQueue.sv
// Product queue
// Circular buffer of partial-product payloads between the generator and
// the accumulate stage. Slave on both links: writes arrive on push,
// reads are served from the head entry on pop

`default_nettype none

`include "mac_config.svh"

module productQueue import macPkg::*; (
    input  wire        Clock,
    input  wire        nReset,
    wishboneLink.slave push,
    wishboneLink.slave pop
);

    localparam int Depth      = `MAC_QUEUE_DEPTH;
    localparam int PtrWidth   = $clog2(Depth);
    localparam int CountBits  = $clog2(Depth + 1);

    partialSet_t          entries [Depth];
    logic [PtrWidth-1:0]  wrPtr;
    logic [PtrWidth-1:0]  rdPtr;
    logic [CountBits-1:0] count;
    logic                 full;
    logic                 empty;
    logic                 writeDone;
    logic                 readDone;

    function automatic logic [PtrWidth-1:0] advance(input logic [PtrWidth-1:0] ptr);
        if (ptr == PtrWidth'(Depth - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign full  = (count == CountBits'(Depth));
    assign empty = (count == '0);

    //----------------------------------------------------------------------
    // Handshake
    //----------------------------------------------------------------------
    assign push.ack  = push.cyc && push.stb && push.we && !full;
    assign pop.ack   = pop.cyc && pop.stb && !pop.we && !empty;
    assign pop.datR  = entries[rdPtr];
    // Nothing is read back on the write link
    assign push.datR = '0;

    assign writeDone = push.stb && push.ack;
    assign readDone  = pop.stb && pop.ack;

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (writeDone)
                wrPtr <= advance(wrPtr);
            if (readDone)
                rdPtr <= advance(rdPtr);
            if (writeDone && !readDone)
                count <= count + 1'b1;
            else if (readDone && !writeDone)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        if (writeDone)
            entries[wrPtr] <= push.datW;
    end

    // Pointer distance always matches the occupancy count
    assert property (@(posedge Clock) disable iff (!nReset)
        (int'(wrPtr) + Depth - int'(rdPtr)) % Depth == int'(count) % Depth);

endmodule

`default_nettype wire

//--- design/wishboneLink.sv
// Wishbone classic link
// Carries one partial-product payload per transfer between two blocks
// inside the multiply-accumulate unit

`default_nettype none

interface wishboneLink import macPkg::*; ();

    logic        cyc;
    logic        stb;
    logic        we;
    partialSet_t datW;
    partialSet_t datR;
    logic        ack;

    // Initiator side
    modport master (
        output cyc,
        output stb,
        output we,
        output datW,
        input  datR,
        input  ack
    );

    // Target side
    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  datW,
        output datR,
        output ack
    );

endinterface

`default_nettype wire

//--- dv/macGolden.txt
// Columns: opCode (0 MultU, 1 MAddU, 2 CountZeros, 3 CountOnes), operandA, operandB,
// expected 64-bit result, all hex; the accumulator starts at zero
0 00000000 00000000 0000000000000000
0 FFFFFFFF FFFFFFFF FFFFFFFE00000001
0 FFFFFFFF 00000000 0000000000000000
0 12345678 00000010 0000000123456780
0 FFFFFFFF 00010000 0000FFFFFFFF0000
0 00000003 FFFFFFFF 00000002FFFFFFFD
0 0000FFFF 0000FFFF 00000000FFFE0001
1 00000002 00000003 00000000FFFE0007
2 00000000 00000000 0000000000000020
1 00000001 00000009 00000000FFFE0010
3 FFFFFFFF 00000000 0000000000000020
1 00000100 00000001 00000000FFFE0110
0 FFFFFFFF FFFFFFFF FFFFFFFE00000001
1 FFFFFFFF FFFFFFFF FFFFFFFC00000002
2 80000000 00000000 0000000000000000
1 FFFFFFFF FFFFFFFF FFFFFFFA00000003
2 00000001 00000000 000000000000001F
3 7FFFFFFF 00000000 0000000000000000
3 FFFF0000 00000000 0000000000000010
2 0000FFFF 00000000 0000000000000010
1 00000001 00000005 FFFFFFFA00000008
3 FFFFFFFE 12345678 000000000000001F
2 00FFFFFF 00000000 0000000000000008
0 DEADBEEF 00000001 00000000DEADBEEF
1 01000000 00000100 00000001DEADBEEF

//--- dv/macUnitTb.sv
// Multiply-accumulate unit testbench
// Replays the operations of the golden file through the valid/ready ports,
// checks every result in order against its expected value and stalls the
// result side with an LFSR pattern plus one long burst to fill the queue

`default_nettype none

`include "mac_config.svh"

module macUnitTb import macPkg::*; ();

    localparam int ClockPeriod  = 4;
    localparam int ResetCycles  = 3;
    localparam int MaxLines     = 64;
    localparam int CyclesPerOp  = 40;
    // Long stall starts once this many results are taken
    localparam int BurstAfter   = 8;
    localparam int BurstCycles  = 30;

    logic                       Clock;
    logic                       nReset;
    logic                       opValid;
    macOp_t                     opCode;
    logic [`MAC_DATA_WIDTH-1:0] operandA;
    logic [`MAC_DATA_WIDTH-1:0] operandB;
    logic                       resultReady;
    logic                       opReady;
    logic                       resultValid;
    logic [AccWidth-1:0]        result;

    // Four words per line: op, A, B, expected
    logic [AccWidth-1:0] golden [4*MaxLines];
    int                  lineCount;
    logic                goldenLoaded;

    int          passCount;
    int          failCount;
    logic        opBlocked;
    logic [15:0] lfsrState;

    macUnit uut (
        .Clock       (Clock),
        .nReset      (nReset),
        .opValid     (opValid),
        .opCode      (opCode),
        .operandA    (operandA),
        .operandB    (operandB),
        .resultReady (resultReady),
        .opReady     (opReady),
        .resultValid (resultValid),
        .result      (result)
    );

    always #(ClockPeriod / 2) Clock = ~Clock;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] stepLfsr(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    function automatic string opLabel(input logic [1:0] code);
        case (code)
            2'd0:    return "MultU";
            2'd1:    return "MAddU";
            2'd2:    return "CountZeros";
            default: return "CountOnes";
        endcase
    endfunction

    //----------------------------------------------------------------------
    // Operation side
    //----------------------------------------------------------------------
    task automatic driveOperations();
        int   sent;
        logic accepted;
        sent = 0;
        while (sent < lineCount) begin
            opValid  = 1'b1;
            opCode   = macOp_t'(golden[4*sent][1:0]);
            operandA = golden[4*sent + 1][`MAC_DATA_WIDTH-1:0];
            operandB = golden[4*sent + 2][`MAC_DATA_WIDTH-1:0];
            accepted = opReady;
            @(negedge Clock);
            if (accepted)
                sent++;
        end
        opValid = 1'b0;
    endtask

    //----------------------------------------------------------------------
    // Result side
    //----------------------------------------------------------------------
    task automatic collectResults();
        int                  taken;
        int                  stallLeft;
        logic                burstDone;
        logic                prevHeld;
        logic [AccWidth-1:0] prevResult;
        logic [AccWidth-1:0] expected;
        taken     = 0;
        stallLeft = 0;
        burstDone = 1'b0;
        prevHeld  = 1'b0;
        prevResult = '0;
        while (taken < lineCount) begin
            if (prevHeld) begin
                assert (resultValid === 1'b1)
                else begin
                    failCount++;
                    $display("[FAIL] %0t: resultValid dropped while the result was stalled",
                        $time);
                end
                assert (result === prevResult)
                else begin
                    failCount++;
                    $display("[FAIL] %0t: result changed while stalled, %h to %h",
                        $time, prevResult, result);
                end
            end

            if (!burstDone && taken == BurstAfter) begin
                stallLeft = BurstCycles;
                burstDone = 1'b1;
            end
            if (stallLeft > 0) begin
                resultReady = 1'b0;
                stallLeft--;
                // Producer blocked while the long stall backs up the pipeline
                if (!opReady)
                    opBlocked = 1'b1;
            end else begin
                lfsrState   = stepLfsr(lfsrState);
                resultReady = lfsrState[0];
            end

            // Taken at the next rising edge
            if (resultValid && resultReady) begin
                expected = golden[4*taken + 3];
                assert (result === expected) begin
                    passCount++;
                    $display("[PASS] line %0d %s result %h", taken + 1,
                        opLabel(golden[4*taken][1:0]), result);
                end else begin
                    failCount++;
                    $display("[FAIL] %0t: line %0d %s expected %h got %h", $time,
                        taken + 1, opLabel(golden[4*taken][1:0]), expected, result);
                end
                taken++;
            end

            prevHeld   = resultValid && !resultReady;
            prevResult = result;
            @(negedge Clock);
        end
        resultReady = 1'b0;
    endtask

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------
    initial begin : mainSequence
        Clock        = 1'b0;
        nReset       = 1'b0;
        opValid      = 1'b0;
        opCode       = MultU;
        operandA     = '0;
        operandB     = '0;
        resultReady  = 1'b0;
        passCount    = 0;
        failCount    = 0;
        opBlocked    = 1'b0;
        lfsrState    = 16'd79;
        lineCount    = 0;
        goldenLoaded = 1'b0;

        $readmemh("dv/macGolden.txt", golden);
        for (int i = 0; i < MaxLines; i++) begin
            if ($isunknown(golden[4*i]))
                break;
            lineCount = i + 1;
        end
        goldenLoaded = 1'b1;
        if (lineCount == 0) begin
            failCount++;
            $display("No operations could be read from the golden file");
        end

        repeat (ResetCycles) @(posedge Clock);
        @(negedge Clock);
        nReset = 1'b1;
        @(negedge Clock);

        assert (opReady === 1'b1 && resultValid === 1'b0) begin
            $display("[PASS] idle state after reset");
        end else begin
            failCount++;
            $display("[FAIL] %0t: after reset opReady %b resultValid %b", $time,
                opReady, resultValid);
        end

        fork
            driveOperations();
            collectResults();
        join

        // The long burst must have backed up to the operation port
        assert (opBlocked === 1'b1)
        else begin
            failCount++;
            $display("opReady never went low during the long result stall");
        end

        $display("Results checked: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    // Watchdog sized from the number of golden lines
    initial begin : watchdog
        wait (goldenLoaded);
        #(ClockPeriod * (ResetCycles + CyclesPerOp * lineCount));
        $display("Timeout: not all results arrived within %0d cycles",
            ResetCycles + CyclesPerOp * lineCount);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
design/macPkg.sv
design/wishboneLink.sv
design/partialProductGen.sv
design/productQueue.sv
design/accumulateCombiner.sv
design/macUnit.sv
dv/macUnitTb.sv

//--- include/mac_config.svh
// Multiply-accumulate unit configuration
// Operand and digit widths for the split multiplier, plus the depth of
// the product queue between the producer and the accumulate stage

`ifndef MAC_CONFIG_SVH
`define MAC_CONFIG_SVH

// Operand width of A and B
`define MAC_DATA_WIDTH 32

// Digit width used for the partial products
`define MAC_DIGIT_WIDTH 8

// Digits per operand
`define MAC_DIGITS 4

// Entries in the product queue
`define MAC_QUEUE_DEPTH 4

`endif
